// File: src/rv_wb_pkg.sv
package rv_wb_pkg;

    localparam int XLEN      = 64;
    localparam int REG_COUNT = 32;

    typedef logic [XLEN-1:0]         xlen_t;      // data word
    typedef logic [4:0]              reg_addr_t;  // x0..x31
    typedef logic signed [31:0]      imm_t;
    typedef logic [XLEN/8-1:0]       byte_mask_t; // one bit per store lane

    typedef enum logic [3:0] {
        op_add,   // rs1 + imm
        op_addw,  // rs1 + imm, low word sign extended
        op_ld,
        op_lw,
        op_lwu,
        op_lh,
        op_sd,
        op_sw,
        op_halt   // stands in for ebreak
    } wb_op_e;

    // decoded command as it enters execute
    typedef struct packed {
        wb_op_e    op;
        reg_addr_t rd;
        reg_addr_t rs1;
        reg_addr_t rs2;
        imm_t      imm;
    } wb_cmd_t;

    typedef struct packed {
        wb_op_e    op;
        reg_addr_t rd;
        xlen_t     sum;         // effective sum, also the address
        xlen_t     store_data;  // rs2 value
    } mem_req_t;

    typedef struct packed {
        wb_op_e    op;
        reg_addr_t rd;
        xlen_t     raw;         // load lane data or sum, not yet extended
    } wb_req_t;

    typedef struct packed {
        reg_addr_t rd;
        logic      wen;
        xlen_t     value;
    } retire_t;

endpackage

// File: src/exec_stage.sv
module exec_stage import rv_wb_pkg::*; (
    input  logic      clk,
    input  logic      rst_n,
    input  logic      cmd_strobe,
    input  wb_cmd_t   cmd,
    input  xlen_t     rs1_data,
    input  xlen_t     rs2_data,
    input  logic      halted,
    output reg_addr_t rs1_addr,
    output reg_addr_t rs2_addr,
    output logic      mem_strobe,
    output mem_req_t  mem_req
);

    logic  halt_seen;  // a halt already went past this step
    logic  accept;
    xlen_t imm_ext;
    xlen_t sum;

    // operand reads go straight from the incoming command
    assign rs1_addr = cmd.rs1;
    assign rs2_addr = cmd.rs2;

    assign imm_ext = {{(XLEN-32){cmd.imm[31]}}, cmd.imm};
    assign sum     = rs1_data + imm_ext;

    // halted comes back from writeback three cycles late,
    // halt_seen closes the gap until then
    assign accept = cmd_strobe && !halted && !halt_seen;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            mem_strobe <= 1'b0;
            halt_seen  <= 1'b0;
        end else begin
            mem_strobe <= accept;
            if (accept && cmd.op == op_halt) begin
                halt_seen <= 1'b1;  // sticky until reset
            end
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            mem_req.op         <= cmd.op;
            mem_req.rd         <= cmd.rd;
            mem_req.sum        <= sum;
            mem_req.store_data <= rs2_data;
        end
    end

endmodule

// File: src/data_mem.sv
module data_mem import rv_wb_pkg::*; #(
    parameter int MEM_WORDS = 256  // depth in doublewords, power of two
) (
    input  logic     clk,
    input  logic     rst_n,
    input  logic     mem_strobe,
    input  mem_req_t mem_req,
    output logic     wb_strobe,
    output wb_req_t  wb_req
);

    localparam int ADDR_BITS = $clog2(MEM_WORDS);

    xlen_t                 mem [MEM_WORDS];
    logic [ADDR_BITS-1:0]  word_idx;
    byte_mask_t            wmask;
    xlen_t                 wdata;
    xlen_t                 rd_word;
    xlen_t                 raw;

    // upper address bits drop off, so accesses wrap
    assign word_idx = mem_req.sum[ADDR_BITS+2:3];
    assign rd_word  = mem[word_idx];

    always_comb begin
        wmask = '0;
        wdata = mem_req.store_data;
        case (mem_req.op)
            op_sd: wmask = '1;
            op_sw: begin
                wmask = mem_req.sum[2] ? 8'hf0 : 8'h0f;  // upper or lower word
                wdata = {2{mem_req.store_data[31:0]}};
            end
            default: wmask = '0;
        endcase
        if (!mem_strobe) begin
            wmask = '0;
        end
    end

    // load lanes are shifted down to bit 0, extension happens in writeback
    always_comb begin
        case (mem_req.op)
            op_ld: raw = rd_word;
            op_lw,
            op_lwu: raw = {32'b0, mem_req.sum[2] ? rd_word[63:32] : rd_word[31:0]};
            op_lh: begin
                case (mem_req.sum[2:1])
                    2'd0:    raw = {48'b0, rd_word[15:0]};
                    2'd1:    raw = {48'b0, rd_word[31:16]};
                    2'd2:    raw = {48'b0, rd_word[47:32]};
                    default: raw = {48'b0, rd_word[63:48]};
                endcase
            end
            default: raw = mem_req.sum;  // add, addw, stores, halt
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < MEM_WORDS; i++) begin
                mem[i] <= '0;
            end
        end else begin
            for (int b = 0; b < XLEN/8; b++) begin
                if (wmask[b]) begin
                    mem[word_idx][8*b +: 8] <= wdata[8*b +: 8];
                end
            end
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wb_strobe <= 1'b0;
        end else begin
            wb_strobe <= mem_strobe;
        end
    end

    always_ff @(posedge clk) begin
        if (mem_strobe) begin
            wb_req.op  <= mem_req.op;
            wb_req.rd  <= mem_req.rd;
            wb_req.raw <= raw;
        end
    end

endmodule

// File: src/wb_stage.sv
module wb_stage import rv_wb_pkg::*; (
    input  logic      clk,
    input  logic      rst_n,
    input  logic      wb_strobe,
    input  wb_req_t   wb_req,
    input  reg_addr_t rs1_addr,
    input  reg_addr_t rs2_addr,
    output xlen_t     rs1_data,
    output xlen_t     rs2_data,
    output logic      retire_strobe,
    output retire_t   retire,
    output logic      halted
);

    xlen_t regs [REG_COUNT];
    xlen_t wb_value;
    logic  is_store;
    logic  is_halt;
    logic  wen;

    function automatic xlen_t extend(wb_op_e op, xlen_t raw);
        case (op)
            op_addw,
            op_lw:   return {{32{raw[31]}}, raw[31:0]};
            op_lwu:  return {32'b0, raw[31:0]};
            op_lh:   return {{48{raw[15]}}, raw[15:0]};
            default: return raw;  // add, ld
        endcase
    endfunction

    assign wb_value = extend(wb_req.op, wb_req.raw);
    assign is_store = wb_req.op == op_sd || wb_req.op == op_sw;
    assign is_halt  = wb_req.op == op_halt;
    assign wen      = wb_strobe && !is_store && !is_halt && wb_req.rd != '0;  // x0 stays zero

    // same-cycle write is visible on the read ports
    assign rs1_data = (wen && rs1_addr == wb_req.rd) ? wb_value : regs[rs1_addr];
    assign rs2_data = (wen && rs2_addr == wb_req.rd) ? wb_value : regs[rs2_addr];

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < REG_COUNT; i++) begin
                regs[i] <= '0;
            end
        end else if (wen) begin
            regs[wb_req.rd] <= wb_value;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            retire_strobe <= 1'b0;
            halted        <= 1'b0;
        end else begin
            retire_strobe <= wb_strobe && !is_halt;  // halt never retires
            if (wb_strobe && is_halt) begin
                halted <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (wb_strobe) begin
            retire.rd    <= wb_req.rd;
            retire.wen   <= wen;
            retire.value <= wen ? wb_value : '0;  // stores and x0 report zero
        end
    end

endmodule

// File: src/wb_core.sv
module wb_core import rv_wb_pkg::*; #(
    parameter int MEM_WORDS = 256
) (
    input  logic    clk,
    input  logic    rst_n,
    input  logic    cmd_strobe,
    input  wb_cmd_t cmd,
    output logic    retire_strobe,
    output retire_t retire,
    output logic    halted
);

    reg_addr_t rs1_addr;
    reg_addr_t rs2_addr;
    xlen_t     rs1_data;
    xlen_t     rs2_data;
    logic      mem_strobe;
    mem_req_t  mem_req;
    logic      wb_strobe;
    wb_req_t   wb_req;

    exec_stage exec_i (
        .clk        (clk),
        .rst_n      (rst_n),
        .cmd_strobe (cmd_strobe),
        .cmd        (cmd),
        .rs1_data   (rs1_data),
        .rs2_data   (rs2_data),
        .halted     (halted),        // fed back from writeback
        .rs1_addr   (rs1_addr),
        .rs2_addr   (rs2_addr),
        .mem_strobe (mem_strobe),
        .mem_req    (mem_req)
    );

    data_mem #(
        .MEM_WORDS (MEM_WORDS)
    ) mem_i (
        .clk        (clk),
        .rst_n      (rst_n),
        .mem_strobe (mem_strobe),
        .mem_req    (mem_req),
        .wb_strobe  (wb_strobe),
        .wb_req     (wb_req)
    );

    wb_stage wb_i (
        .clk           (clk),
        .rst_n         (rst_n),
        .wb_strobe     (wb_strobe),
        .wb_req        (wb_req),
        .rs1_addr      (rs1_addr),
        .rs2_addr      (rs2_addr),
        .rs1_data      (rs1_data),
        .rs2_data      (rs2_data),
        .retire_strobe (retire_strobe),
        .retire        (retire),
        .halted        (halted)
    );

endmodule

// File: tests/tb_model.svh
`ifndef TB_MODEL_SVH
`define TB_MODEL_SVH

typedef struct packed {
    logic [31:0] cyc;  // issue cycle
    retire_t     ret;
} exp_item_t;

typedef struct packed {
    logic [31:0] cyc;
    reg_addr_t   rd;
    xlen_t       value;
} reg_write_t;

xlen_t       model_regs [REG_COUNT] = '{default: '0};
xlen_t       model_mem [MEM_WORDS]  = '{default: '0};
exp_item_t   exp_q [$];
reg_write_t  pend_q [$];  // writes the read ports cannot see yet
logic        halt_set  = 1'b0;
logic [31:0] halt_cyc  = '0;
logic [31:0] rng_state = 32'h822b113f;

function automatic logic [31:0] next_rand();
    rng_state ^= rng_state << 13;
    rng_state ^= rng_state >> 17;
    rng_state ^= rng_state << 5;
    return rng_state;
endfunction

// a result shows up on the read ports two cycles after its command
function automatic void apply_visible(logic [31:0] now);
    while (pend_q.size() > 0 && pend_q[0].cyc + 32'd2 <= now) begin
        model_regs[pend_q[0].rd] = pend_q[0].value;
        void'(pend_q.pop_front());
    end
endfunction

function automatic void model_issue(wb_cmd_t c, logic [31:0] now);
    xlen_t      addr;
    xlen_t      word;
    xlen_t      lane;
    xlen_t      half;
    xlen_t      src;
    xlen_t      value;
    mem_idx_t   idx;
    exp_item_t  item;
    reg_write_t wr;
    if (halt_set) begin
        return;  // dropped once a halt went in
    end
    if (c.op == op_halt) begin
        halt_set = 1'b1;
        halt_cyc = now;
        return;
    end
    apply_visible(now);
    addr  = model_regs[c.rs1] + {{32{c.imm[31]}}, c.imm};
    src   = model_regs[c.rs2];
    idx   = mem_idx_t'((addr >> 3) % xlen_t'(MEM_WORDS));  // wraps over the byte range
    word  = model_mem[idx];
    lane  = word >> {addr[2], 5'b0};
    half  = word >> {addr[2:1], 4'b0};
    value = '0;
    case (c.op)
        op_add:  value = addr;
        op_addw: value = {{32{addr[31]}}, addr[31:0]};
        op_ld:   value = word;
        op_lw:   value = {{32{lane[31]}}, lane[31:0]};
        op_lwu:  value = {32'b0, lane[31:0]};
        op_lh:   value = {{48{half[15]}}, half[15:0]};
        op_sd:   model_mem[idx] = src;
        op_sw: begin
            if (addr[2]) begin
                model_mem[idx][63:32] = src[31:0];
            end else begin
                model_mem[idx][31:0] = src[31:0];
            end
        end
        default: value = '0;
    endcase
    item.cyc       = now;
    item.ret.rd    = c.rd;
    item.ret.wen   = c.op != op_sd && c.op != op_sw && c.rd != 5'd0;
    item.ret.value = item.ret.wen ? value : '0;
    exp_q.push_back(item);
    if (item.ret.wen) begin
        wr.cyc   = now;
        wr.rd    = c.rd;
        wr.value = value;
        pend_q.push_back(wr);
    end
endfunction

`endif

// File: tests/tb_wb_core.sv
module tb_wb_core import rv_wb_pkg::*; ();

    localparam int MEM_WORDS   = 256;
    localparam int N_ARITH     = 32;
    localparam int N_MEM       = 64;
    localparam int STIM_CYCLES = 4 + (REG_COUNT - 1) + 32 + 2 * N_ARITH + N_MEM + 1 + 28;
    localparam int CYCLE_LIMIT = STIM_CYCLES + 20;

    typedef logic [$clog2(MEM_WORDS)-1:0] mem_idx_t;

    logic        clk = 1'b0;
    logic        rst_n;
    logic        cmd_strobe;
    wb_cmd_t     cmd;
    logic        retire_strobe;
    retire_t     retire;
    logic        halted;
    logic [31:0] cyc = '0;
    logic        due;
    int          n_mismatch = 0;
    int          n_other    = 0;

    `include "tb_model.svh"

    wb_core #(
        .MEM_WORDS (MEM_WORDS)
    ) dut_i (
        .clk           (clk),
        .rst_n         (rst_n),
        .cmd_strobe    (cmd_strobe),
        .cmd           (cmd),
        .retire_strobe (retire_strobe),
        .retire        (retire),
        .halted        (halted)
    );

    always #4 clk = ~clk;

    always @(posedge clk) begin
        cyc <= cyc + 32'd1;
    end

    task automatic issue(input wb_op_e op, input reg_addr_t rd, input reg_addr_t rs1,
                         input reg_addr_t rs2, input imm_t imm);
        wb_cmd_t c;
        c.op  = op;
        c.rd  = rd;
        c.rs1 = rs1;
        c.rs2 = rs2;
        c.imm = imm;
        @(posedge clk);
        cmd_strobe <= 1'b1;
        cmd        <= c;
        model_issue(c, cyc);
    endtask

    task automatic idle();
        @(posedge clk);
        cmd_strobe <= 1'b0;
    endtask

    function automatic wb_op_e pick_mem_op(logic [2:0] sel);
        case (sel)
            3'd0, 3'd6: return op_sd;
            3'd1:       return op_sw;
            3'd2:       return op_ld;
            3'd3, 3'd7: return op_lw;
            3'd4:       return op_lwu;
            default:    return op_lh;
        endcase
    endfunction

    // retirement due exactly four edges after the issuing edge
    always @(posedge clk) begin
        if (rst_n) begin
            due = exp_q.size() > 0 && exp_q[0].cyc + 32'd4 == cyc;
            assert (retire_strobe || !due) else begin
                $display("expected retirement did not appear at time %0t", $time);
                n_other++;
            end
            assert (!retire_strobe || exp_q.size() > 0) else begin
                $display("retire strobe with no command outstanding at time %0t", $time);
                n_other++;
            end
            assert (!retire_strobe || due || exp_q.size() == 0) else begin
                $display("retirement came at the wrong cycle at time %0t", $time);
                n_other++;
            end
            if (due && retire_strobe) begin
                assert (retire == exp_q[0].ret) else begin
                    $display("Mismatch at %0t: got rd %0d wen %b value %h", $time,
                             retire.rd, retire.wen, retire.value);
                    $display("  expected rd %0d wen %b value %h",
                             exp_q[0].ret.rd, exp_q[0].ret.wen, exp_q[0].ret.value);
                    n_mismatch++;
                end
            end
            if (due) begin
                void'(exp_q.pop_front());
            end
            assert (halted == (halt_set && cyc >= halt_cyc + 32'd4)) else begin
                $display("Mismatch at %0t: halted is %b", $time, halted);
                n_mismatch++;
            end
        end
    end

    initial begin
        imm_t        edge_imms [8];
        logic [31:0] r;
        imm_t        off;
        reg_addr_t   base;
        rst_n      = 1'b0;
        cmd_strobe = 1'b0;
        cmd        = '0;
        edge_imms  = '{32'h7fff_ffff, 32'h8000_0000, 32'hffff_ffff, 32'h0000_0001,
                       32'h0000_7fff, 32'hffff_8000, 32'h0000_0000, 32'h4000_0000};
        repeat (4) @(posedge clk);
        rst_n <= 1'b1;
        for (int i = 1; i < REG_COUNT; i++) begin
            issue(op_add, reg_addr_t'(i), reg_addr_t'(i), 5'd0, 32'd0);  // reset value
        end
        for (int k = 0; k < 8; k++) begin
            issue(op_add, reg_addr_t'(k + 1), 5'd0, 5'd0, edge_imms[k[2:0]]);
            idle();
            issue(op_addw, reg_addr_t'(k + 9), reg_addr_t'(k + 1), 5'd0, edge_imms[k[2:0]]);
            idle();
        end
        for (int n = 0; n < N_ARITH; n++) begin
            r = next_rand();
            issue(r[0] ? op_addw : op_add, r[5:1], r[10:6], r[15:11], next_rand());
            idle();
        end
        for (int n = 0; n < N_MEM; n++) begin
            r    = next_rand();
            off  = next_rand() & 32'h0000_00ff;  // low bits hit the ignored alignment
            base = (r[20:18] == 3'd0) ? r[17:13] : 5'd0;
            if (r[31]) begin
                off = off - MEM_WORDS * 8;  // negative offset wraps onto the same lines
            end
            issue(pick_mem_op(r[2:0]), r[7:3], base, r[25:21], off);
        end
        idle();
        issue(op_add, 5'd0, 5'd1, 5'd0, 32'h55);  // x0 keeps zero
        idle();
        issue(op_lw, 5'd0, 5'd0, 5'd0, 32'h8);
        idle();
        issue(op_add, 5'd5, 5'd0, 5'd0, 32'd0);
        idle();
        issue(op_add, 5'd7, 5'd0, 5'd0, 32'd100);
        issue(op_add, 5'd8, 5'd7, 5'd0, 32'd1);  // old r7
        issue(op_add, 5'd9, 5'd7, 5'd0, 32'd2);  // new r7
        idle();
        issue(op_halt, 5'd0, 5'd0, 5'd0, 32'd0);
        issue(op_add, 5'd10, 5'd0, 5'd0, 32'd1);  // inside the halt window
        issue(op_add, 5'd11, 5'd0, 5'd0, 32'd2);
        idle();
        repeat (4) @(posedge clk);
        issue(op_add, 5'd12, 5'd0, 5'd0, 32'd3);
        idle();
        while (exp_q.size() != 0) begin
            @(posedge clk);
        end
        repeat (8) @(posedge clk);
        $display("errors: %0d mismatches, %0d other", n_mismatch, n_other);
        if (n_mismatch == 0 && n_other == 0) begin
            $display("Test passed");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

    initial begin
        while (cyc < CYCLE_LIMIT) begin
            @(posedge clk);
        end
        $display("timeout: run did not finish within %0d cycles", CYCLE_LIMIT);
        $display("Test failed");
        $finish;
    end

endmodule

// File: build.f
+incdir+tests
src/rv_wb_pkg.sv
src/exec_stage.sv
src/data_mem.sv
src/wb_stage.sv
src/wb_core.sv
tests/tb_wb_core.sv

// File: run.sh
#!/bin/sh
# Compile and run the testbench with Verilator, then check the log.
set -e
cd "$(dirname "$0")"

rm -rf obj_dir sim.log

verilator --binary --timing --assert -f build.f --top-module tb_wb_core -o tb_wb_core_sim

./obj_dir/tb_wb_core_sim > sim.log 2>&1 || true
cat sim.log

if grep -qx "Test passed" sim.log; then
    echo "simulation ok"
    exit 0
fi

echo "simulation did not pass"
exit 1
